// ==== source/cim_cfg_pkg.sv ====
// MEM_DEPTH must be a power of two; patch data fills addresses 0 to PATCH_LEN-1
package cim_cfg_pkg;

    // Word formats
    localparam int N_STORAGE = 16;
    localparam int N_COMP    = 32;
    localparam int FRAC_BITS = 8;      // Q7.8 storage words

    // Patch geometry
    localparam int PATCH_LEN   = 8;
    localparam int NUM_PATCHES = 4;

    // Memory map
    localparam int MEM_DEPTH   = 64;
    localparam int ADDR_W      = $clog2(MEM_DEPTH);
    localparam int BIAS_ADDR   = PATCH_LEN;   // Right after the weights
    localparam int RESULT_BASE = 32;          // One result word per patch

    typedef logic signed [N_STORAGE-1:0] storage_word_t;
    typedef logic signed [N_COMP-1:0]    comp_word_t;
    typedef logic [ADDR_W-1:0]           mem_addr_t;

endpackage

// ==== source/cim_bus_pkg.sv ====
// Single-node view of the command bus; requesters must not overlap, priority only breaks ties
package cim_bus_pkg;

    import cim_cfg_pkg::*;

    localparam int NUM_MEM_SRC = 4;

    typedef enum logic [2:0] {
        NOP                   = 3'd0,
        PARAM_STREAM_START_OP = 3'd1,
        PARAM_STREAM_OP       = 3'd2,
        PATCH_LOAD_START_OP   = 3'd3,
        PATCH_LOAD_OP         = 3'd4,
        RESULT_READ_OP        = 3'd5
    } bus_op_t;

    typedef logic [1:0] node_id_t;

    typedef struct packed {
        bus_op_t             op;
        node_id_t            target;
        storage_word_t [2:0] data;
    } bus_cmd_t;

    typedef struct packed {
        logic                valid;   // One-cycle pulse, data holds afterwards
        storage_word_t [2:0] data;
    } bus_resp_t;

    typedef struct packed {
        logic          read;
        logic          write;
        mem_addr_t     addr;
        storage_word_t wdata;
    } mem_req_t;

    // Highest priority first
    typedef enum logic [1:0] {
        SRC_BUS,
        SRC_CTRL,
        SRC_MAC,
        SRC_TX
    } mem_src_t;

endpackage

// ==== source/cim_mem.sv ====
// Single-port banks, one access per cycle each; read data is valid one cycle after the request
`timescale 1ns/1ps

module cim_mem import cim_cfg_pkg::*, cim_bus_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mem_req_t [NUM_MEM_SRC-1:0]   param_reqs,
    input  mem_req_t [NUM_MEM_SRC-1:0]   int_res_reqs,
    output storage_word_t                param_rdata,
    output storage_word_t                int_res_rdata
);

    // Bank 0 holds parameters, bank 1 intermediate results
    mem_req_t [NUM_MEM_SRC-1:0] bank_reqs [2];
    storage_word_t              bank_rdata [2];

    assign bank_reqs[0]  = param_reqs;
    assign bank_reqs[1]  = int_res_reqs;
    assign param_rdata   = bank_rdata[0];
    assign int_res_rdata = bank_rdata[1];

    for (genvar b = 0; b < 2; b++) begin : g_bank
        storage_word_t words [MEM_DEPTH];
        mem_req_t      win;

        always_comb begin
            win = '0;
            // Walk up from the lowest priority so SRC_BUS ends up on top
            for (int s = NUM_MEM_SRC - 1; s >= 0; s--) begin
                if (bank_reqs[b][s].read || bank_reqs[b][s].write) begin
                    win = bank_reqs[b][s];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (win.write) begin
                words[win.addr] <= win.wdata;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                bank_rdata[b] <= '0;
            end else if (win.read) begin
                bank_rdata[b] <= words[win.addr];   // Holds until the next read
            end
        end
    end

endmodule

// ==== source/cim_bus_rx.sv ====
// Host must hold off while busy; start ops act on every node, stream and read ops only on node_id
`timescale 1ns/1ps

module cim_bus_rx import cim_cfg_pkg::*, cim_bus_pkg::*; #(
    parameter node_id_t node_id = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  bus_cmd_t  cmd,
    output mem_req_t  param_req,
    output mem_req_t  int_res_req,
    output logic      patch_full,
    output logic      send_start,
    output mem_addr_t send_addr,
    output logic      busy
);

    logic                         for_me;
    mem_addr_t                    stream_base;
    mem_addr_t                    word_cnt;
    logic [1:0]                   drain_left;
    storage_word_t [2:0]          stream_buf;
    logic [$clog2(PATCH_LEN)-1:0] patch_cnt;

    assign for_me = (cmd.target == node_id);
    assign busy   = param_req.write;   // High for the three stream writes

    always_ff @(posedge clk) begin
        if (cmd.op == PARAM_STREAM_OP && for_me) begin
            stream_buf <= cmd.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            param_req   <= '0;
            int_res_req <= '0;
            patch_full  <= 1'b0;
            send_start  <= 1'b0;
            send_addr   <= '0;
            stream_base <= '0;
            word_cnt    <= '0;
            drain_left  <= '0;
            patch_cnt   <= '0;
        end else begin
            param_req.write   <= 1'b0;
            int_res_req.write <= 1'b0;
            patch_full        <= 1'b0;
            send_start        <= 1'b0;

            if (drain_left != 2'd0) begin   // Words 1 and 2 from the buffer
                param_req.write <= 1'b1;
                param_req.addr  <= stream_base + word_cnt;
                param_req.wdata <= stream_buf[2'd3 - drain_left];
                word_cnt        <= word_cnt + 1'b1;
                drain_left      <= drain_left - 1'b1;
            end

            case (cmd.op)
                PARAM_STREAM_START_OP: begin
                    stream_base <= cmd.data[0][ADDR_W-1:0];
                    word_cnt    <= '0;
                end
                PARAM_STREAM_OP: begin
                    if (for_me) begin
                        param_req.write <= 1'b1;
                        param_req.addr  <= stream_base + word_cnt;
                        param_req.wdata <= cmd.data[0];
                        word_cnt        <= word_cnt + 1'b1;
                        drain_left      <= 2'd2;
                    end
                end
                PATCH_LOAD_START_OP: patch_cnt <= '0;
                PATCH_LOAD_OP: begin
                    int_res_req.write <= 1'b1;
                    int_res_req.addr  <= mem_addr_t'(patch_cnt);
                    int_res_req.wdata <= cmd.data[0];
                    patch_full        <= (patch_cnt == PATCH_LEN - 1);
                    // Wraps so the next patch can follow without a start op
                    patch_cnt <= (patch_cnt == PATCH_LEN - 1) ? '0 : patch_cnt + 1'b1;
                end
                RESULT_READ_OP: begin
                    if (for_me) begin
                        send_start <= 1'b1;
                        send_addr  <= cmd.data[0][ADDR_W-1:0];
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== source/cim_mac.sv ====
// Fixed latency of PATCH_LEN+4 cycles; expects sole use of both memories while running, no saturation
`timescale 1ns/1ps

module cim_mac import cim_cfg_pkg::*, cim_bus_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    output mem_req_t      param_req,
    output mem_req_t      int_res_req,
    input  storage_word_t param_rdata,
    input  storage_word_t int_res_rdata,
    output logic          done,
    output comp_word_t    result
);

    typedef enum logic [1:0] {MAC_IDLE, MAC_RUN, MAC_BIAS, MAC_DONE} mac_state_t;

    mac_state_t                   state;
    logic [$clog2(PATCH_LEN)-1:0] rd_idx;
    logic                         data_valid, prod_valid, bias_valid, sum_valid;
    comp_word_t                   prod, acc;
    comp_word_t                   prod_term, bias_term;

    always_comb begin
        prod_term = '0;
        bias_term = '0;
        if (prod_valid) prod_term = prod >>> FRAC_BITS;
        if (bias_valid) bias_term = param_rdata;   // Integer aligned, sign extended
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= MAC_IDLE;
            rd_idx      <= '0;
            param_req   <= '0;
            int_res_req <= '0;
            data_valid  <= 1'b0;
            prod_valid  <= 1'b0;
            bias_valid  <= 1'b0;
            sum_valid   <= 1'b0;
            done        <= 1'b0;
        end else begin
            done       <= 1'b0;
            data_valid <= int_res_req.read;
            bias_valid <= param_req.read && !int_res_req.read;   // Only the bias read
            prod_valid <= data_valid;
            sum_valid  <= bias_valid;

            case (state)
                MAC_IDLE: begin
                    if (start) begin
                        param_req.read   <= 1'b1;
                        int_res_req.read <= 1'b1;
                        param_req.addr   <= '0;
                        int_res_req.addr <= '0;
                        rd_idx           <= 1'b1;
                        state            <= MAC_RUN;
                    end
                end
                MAC_RUN: begin
                    param_req.addr   <= mem_addr_t'(rd_idx);
                    int_res_req.addr <= mem_addr_t'(rd_idx);
                    rd_idx           <= rd_idx + 1'b1;
                    if (rd_idx == PATCH_LEN - 1) state <= MAC_BIAS;
                end
                MAC_BIAS: begin
                    param_req.addr   <= mem_addr_t'(BIAS_ADDR);
                    int_res_req.read <= 1'b0;
                    state            <= MAC_DONE;
                end
                MAC_DONE: begin
                    param_req.read <= 1'b0;
                    if (sum_valid) begin   // Bias and last product are in
                        done  <= 1'b1;
                        state <= MAC_IDLE;
                    end
                end
                default: state <= MAC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid) prod <= comp_word_t'(param_rdata) * comp_word_t'(int_res_rdata);
        if (state == MAC_IDLE) begin
            acc <= '0;
        end else begin
            acc <= acc + prod_term + bias_term;
        end
        if (sum_valid) result <= acc;
    end

endmodule

// ==== source/cim_compute_ctrl.sv ====
// One MAC per full patch; results land at RESULT_BASE plus a patch index that wraps at NUM_PATCHES
`timescale 1ns/1ps

module cim_compute_ctrl import cim_cfg_pkg::*, cim_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       patch_full,
    output logic       mac_start,
    input  logic       mac_done,
    input  comp_word_t mac_result,
    output mem_req_t   int_res_req,
    output logic       busy
);

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_MAC, CTRL_STORE} ctrl_state_t;

    ctrl_state_t                    state;
    logic [$clog2(NUM_PATCHES)-1:0] patch_idx;

    // Covers the patch_full cycle so the host stops before the MAC reads
    assign busy = patch_full || (state != CTRL_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= CTRL_IDLE;
            mac_start   <= 1'b0;
            int_res_req <= '0;
            patch_idx   <= '0;
        end else begin
            mac_start         <= 1'b0;
            int_res_req.write <= 1'b0;

            case (state)
                CTRL_IDLE: begin
                    if (patch_full) begin
                        mac_start <= 1'b1;
                        state     <= CTRL_MAC;
                    end
                end
                CTRL_MAC: begin
                    if (mac_done) begin
                        int_res_req.write <= 1'b1;
                        int_res_req.addr  <= mem_addr_t'(RESULT_BASE) + mem_addr_t'(patch_idx);
                        int_res_req.wdata <= mac_result[N_STORAGE-1:0];   // Low bits only
                        state             <= CTRL_STORE;
                    end
                end
                CTRL_STORE: begin   // Write goes out this cycle
                    patch_idx <= (patch_idx == NUM_PATCHES - 1) ? '0 : patch_idx + 1'b1;
                    state     <= CTRL_IDLE;
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

// ==== source/cim_tx.sv ====
// Always sends exactly three consecutive words; start_addr+2 must stay inside the memory
`timescale 1ns/1ps

module cim_tx import cim_cfg_pkg::*, cim_bus_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  mem_addr_t     start_addr,
    output mem_req_t      int_res_req,
    input  storage_word_t int_res_rdata,
    output bus_resp_t     resp,
    output logic          busy
);

    typedef enum logic {TX_IDLE, TX_FILL} tx_state_t;

    tx_state_t  state;
    mem_addr_t  base_addr;
    logic [1:0] req_cnt;
    logic [1:0] cap_idx;
    logic       rd_valid;

    assign busy = start || (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= TX_IDLE;
            base_addr   <= '0;
            req_cnt     <= '0;
            cap_idx     <= '0;
            rd_valid    <= 1'b0;
            int_res_req <= '0;
            resp        <= '0;
        end else begin
            resp.valid <= 1'b0;
            rd_valid   <= int_res_req.read;

            case (state)
                TX_IDLE: begin
                    if (start) begin
                        base_addr        <= start_addr;
                        int_res_req.read <= 1'b1;
                        int_res_req.addr <= start_addr;
                        req_cnt          <= 2'd1;
                        cap_idx          <= '0;
                        state            <= TX_FILL;
                    end
                end
                TX_FILL: begin
                    if (req_cnt != 2'd3) begin
                        int_res_req.addr <= base_addr + mem_addr_t'(req_cnt);
                        req_cnt          <= req_cnt + 1'b1;
                    end else begin
                        int_res_req.read <= 1'b0;
                    end
                    if (rd_valid) begin
                        resp.data[cap_idx] <= int_res_rdata;
                        cap_idx            <= cap_idx + 1'b1;
                        if (cap_idx == 2'd2) begin   // Last word captured
                            resp.valid <= 1'b1;
                            state      <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

// ==== source/cim_top.sv ====
// One node only; the host must send NOP whenever is_ready is low
`timescale 1ns/1ps

module cim_top import cim_cfg_pkg::*, cim_bus_pkg::*; #(
    parameter node_id_t node_id = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  bus_cmd_t  cmd,
    output bus_resp_t resp,
    output logic      is_ready
);

    wire mem_req_t [NUM_MEM_SRC-1:0] param_reqs;
    wire mem_req_t [NUM_MEM_SRC-1:0] int_res_reqs;
    storage_word_t param_rdata, int_res_rdata;
    logic          patch_full, mac_start, mac_done, send_start;
    logic          rx_busy, ctrl_busy, tx_busy;
    comp_word_t    mac_result;
    mem_addr_t     send_addr;

    // Only rx and mac touch the parameter memory
    assign param_reqs[SRC_CTRL] = '0;
    assign param_reqs[SRC_TX]   = '0;

    assign is_ready = !(rx_busy || ctrl_busy || tx_busy);

    cim_mem mem (
        .clk(clk), .rst_n(rst_n),
        .param_reqs(param_reqs), .int_res_reqs(int_res_reqs),
        .param_rdata(param_rdata), .int_res_rdata(int_res_rdata)
    );

    cim_bus_rx #(.node_id(node_id)) rx (
        .clk(clk), .rst_n(rst_n), .cmd(cmd),
        .param_req(param_reqs[SRC_BUS]), .int_res_req(int_res_reqs[SRC_BUS]),
        .patch_full(patch_full), .send_start(send_start), .send_addr(send_addr),
        .busy(rx_busy)
    );

    cim_compute_ctrl ctrl (
        .clk(clk), .rst_n(rst_n), .patch_full(patch_full),
        .mac_start(mac_start), .mac_done(mac_done), .mac_result(mac_result),
        .int_res_req(int_res_reqs[SRC_CTRL]), .busy(ctrl_busy)
    );

    cim_mac mac (
        .clk(clk), .rst_n(rst_n), .start(mac_start),
        .param_req(param_reqs[SRC_MAC]), .int_res_req(int_res_reqs[SRC_MAC]),
        .param_rdata(param_rdata), .int_res_rdata(int_res_rdata),
        .done(mac_done), .result(mac_result)
    );

    cim_tx tx (
        .clk(clk), .rst_n(rst_n), .start(send_start), .start_addr(send_addr),
        .int_res_req(int_res_reqs[SRC_TX]), .int_res_rdata(int_res_rdata),
        .resp(resp), .busy(tx_busy)
    );

endmodule

// ==== tb/cim_tb_checks.svh ====
// Included inside the testbench module, which must import cim_cfg_pkg and cim_bus_pkg first
`ifndef CIM_TB_CHECKS_SVH
`define CIM_TB_CHECKS_SVH

int check_cnt    = 0;
int mismatch_cnt = 0;
int fail_cnt     = 0;   // Timeouts, stray responses, bad records

task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t expected);
    check_cnt++;
    if (got !== expected) begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
    end
endtask

task automatic check_word(input string name, input storage_word_t got,
                          input storage_word_t expected);
    check_cnt++;
    if (got !== expected) begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
    end
endtask

task automatic check_ready(input string name, input logic got, input logic expected);
    check_cnt++;
    if (got !== expected) begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, expected);
    end
endtask

// Galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

`endif

// ==== tb/cim_tb.sv ====
// Run from the project root; reads tb/cim_input.txt and drives a single node with id 1
`timescale 1ns/1ps

module cim_tb import cim_cfg_pkg::*, cim_bus_pkg::*;;

    localparam int       CLK_PERIOD = 40;
    localparam node_id_t NODE_ID    = 2'd1;
    localparam int       MAX_RECS   = 64;
    localparam int       WAIT_LIMIT = 64;   // Cycles allowed per command

    logic      clk;
    logic      rst_n;
    bus_cmd_t  cmd;
    bus_resp_t resp;
    logic      is_ready;

    byte           rec_tag [MAX_RECS];
    logic [31:0]   rec_fld [MAX_RECS][5];
    int            rec_cnt      = 0;
    logic          loaded       = 1'b0;
    logic [31:0]   lfsr         = 32'h1aaa3127;
    logic          read_pending = 1'b0;
    bus_resp_t     got_resp;
    bus_resp_t     last_resp;
    int            patch_words  = 0;
    int            next_idx     = 0;
    int            last_idx     = 0;
    storage_word_t weights [PATCH_LEN+1];   // Bias in the last slot
    storage_word_t patch   [PATCH_LEN];

    `include "cim_tb_checks.svh"

    cim_top #(.node_id(NODE_ID)) uut (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .resp(resp), .is_ready(is_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic finish_run();
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 check_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Every wait after reset goes through here so a stray response is caught
    task automatic next_cycle();
        @(negedge clk);
        if (resp.valid) begin
            if (read_pending) begin
                got_resp     = resp;
                read_pending = 1'b0;
            end else begin
                fail_cnt++;
                $display("ERROR at %0t: response valid with no read outstanding", $time);
            end
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!is_ready && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!is_ready) begin
            fail_cnt++;
            $display("ERROR at %0t: is_ready stayed low for %0d cycles", $time, n);
        end
    endtask

    task automatic issue_cmd(input bus_op_t op, input node_id_t target,
                             input storage_word_t d0, input storage_word_t d1,
                             input storage_word_t d2);
        wait_ready();
        cmd.op      = op;
        cmd.target  = target;
        cmd.data[0] = d0;
        cmd.data[1] = d1;
        cmd.data[2] = d2;
        if (op == PATCH_LOAD_START_OP) patch_words = 0;
        if (op == PATCH_LOAD_OP) begin
            patch_words++;
            if (patch_words == PATCH_LEN) begin   // Patch complete, result index taken
                patch_words = 0;
                last_idx    = next_idx;
                next_idx    = (next_idx + 1) % NUM_PATCHES;
            end
        end
        next_cycle();
        cmd = '0;
    endtask

    task automatic read_words(input node_id_t target, input mem_addr_t addr,
                              output bus_resp_t got);
        int n;
        n = 0;
        read_pending = (target == NODE_ID);
        issue_cmd(RESULT_READ_OP, target, storage_word_t'(addr), '0, '0);
        if (target == NODE_ID) begin
            while (read_pending && n < WAIT_LIMIT) begin
                next_cycle();
                n++;
            end
            if (read_pending) begin
                fail_cnt++;
                read_pending = 1'b0;
                $display("ERROR at %0t: no response to read at address %0d", $time, addr);
            end
        end else begin
            repeat (WAIT_LIMIT) next_cycle();   // Other node, must stay silent
        end
        got = got_resp;
    endtask

    task automatic draw_word(output storage_word_t w);
        for (int b = 0; b < N_STORAGE; b++) begin
            w[b] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Q7.8 products shifted back by FRAC_BITS, bias added as a plain integer
    function automatic storage_word_t mac_expect();
        int sum;
        sum = int'(weights[BIAS_ADDR]);
        for (int i = 0; i < PATCH_LEN; i++) begin
            sum += (int'(weights[i]) * int'(patch[i])) >>> FRAC_BITS;
        end
        return storage_word_t'(sum[N_STORAGE-1:0]);
    endfunction

    task automatic random_patch();
        bus_resp_t got;
        for (int i = 0; i <= PATCH_LEN; i++) draw_word(weights[i]);
        for (int i = 0; i < PATCH_LEN; i++) draw_word(patch[i]);
        issue_cmd(PARAM_STREAM_START_OP, NODE_ID, '0, '0, '0);
        for (int i = 0; i <= PATCH_LEN; i += 3) begin
            issue_cmd(PARAM_STREAM_OP, NODE_ID, weights[i], weights[i+1], weights[i+2]);
            check_ready("is_ready", is_ready, 1'b0);
        end
        issue_cmd(PATCH_LOAD_START_OP, NODE_ID, '0, '0, '0);
        for (int i = 0; i < PATCH_LEN; i++) issue_cmd(PATCH_LOAD_OP, NODE_ID, patch[i], '0, '0);
        read_words(NODE_ID, mem_addr_t'(RESULT_BASE + last_idx), got);
        check_word("resp.data[0]", got.data[0], mac_expect());
    endtask

    task automatic load_records();
        int          fd;
        int          ch;
        byte         tag;
        logic        ok;
        logic [31:0] f0, f1, f2, f3, f4;
        fd = $fopen("tb/cim_input.txt", "r");
        if (fd == 0) begin
            fail_cnt++;
            $display("ERROR: cannot open tb/cim_input.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "#") begin
                    do ch = $fgetc(fd); while (ch != 10 && ch != -1);
                end else begin
                    f0 = '0;
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    f4 = '0;
                    case (tag)
                        "C": ok = ($fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4) == 5);
                        "R": ok = ($fscanf(fd, "%h %h %h", f0, f1, f2) == 3);
                        "E": ok = ($fscanf(fd, "%h %h", f0, f1) == 2);
                        "G": ok = ($fscanf(fd, "%d", f0) == 1);
                        default: ok = 1'b0;
                    endcase
                    if (!ok || rec_cnt == MAX_RECS) begin
                        fail_cnt++;
                        $display("ERROR: input record %0d is malformed or too many", rec_cnt);
                        break;
                    end
                    rec_tag[rec_cnt]    = tag;
                    rec_fld[rec_cnt][0] = f0;
                    rec_fld[rec_cnt][1] = f1;
                    rec_fld[rec_cnt][2] = f2;
                    rec_fld[rec_cnt][3] = f3;
                    rec_fld[rec_cnt][4] = f4;
                    rec_cnt++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic run_record(input int r);
        bus_resp_t want;
        bus_op_t   op;
        node_id_t  target;
        op     = bus_op_t'(rec_fld[r][0][2:0]);
        target = node_id_t'(rec_fld[r][1][1:0]);
        case (rec_tag[r])
            "C": begin
                if (op == RESULT_READ_OP) begin
                    read_words(target, mem_addr_t'(rec_fld[r][2]), last_resp);
                end else begin
                    issue_cmd(op, target, rec_fld[r][2][15:0], rec_fld[r][3][15:0],
                              rec_fld[r][4][15:0]);
                    if (op == PARAM_STREAM_OP && target == NODE_ID) begin
                        check_ready("is_ready", is_ready, 1'b0);   // Stream writes running
                    end
                end
            end
            "R": begin
                want.valid   = 1'b1;
                want.data[0] = rec_fld[r][0][15:0];
                want.data[1] = rec_fld[r][1][15:0];
                want.data[2] = rec_fld[r][2][15:0];
                check_resp("resp", last_resp, want);
            end
            "E": begin
                read_words(NODE_ID, mem_addr_t'(RESULT_BASE + rec_fld[r][0]), last_resp);
                check_word("resp.data[0]", last_resp.data[0], rec_fld[r][1][15:0]);
            end
            "G": repeat (rec_fld[r][0]) random_patch();
            default: begin
            end
        endcase
    endtask

    initial begin
        rst_n = 1'b0;
        cmd   = '0;
        load_records();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        check_ready("is_ready", is_ready, 1'b1);
        for (int r = 0; r < rec_cnt; r++) run_record(r);
        repeat (4) next_cycle();
        finish_run();
    end

    // Watchdog
    initial begin
        wait (loaded);
        #((rec_cnt + 1) * WAIT_LIMIT * CLK_PERIOD + 16 * CLK_PERIOD);
        fail_cnt++;
        $display("ERROR at %0t: watchdog expired before the last record finished", $time);
        finish_run();
    end

endmodule

// ==== cim.f ====
+incdir+tb
source/cim_cfg_pkg.sv
source/cim_bus_pkg.sv
source/cim_mem.sv
source/cim_bus_rx.sv
source/cim_mac.sv
source/cim_compute_ctrl.sv
source/cim_tx.sv
source/cim_top.sv
tb/cim_tb.sv

// ==== tb/cim_input.txt ====
# C op target d0 d1 d2: bus command in hex; R w0 w1 w2: words expected from the last read
# E idx word: expected result at RESULT_BASE+idx; G n: patches of LFSR weights and words
C 1 1 0000 0000 0000
C 2 1 0100 0200 FF00
C 2 1 0080 0100 FE00
C 2 1 0040 0300 0010
C 3 1 0000 0000 0000
C 4 1 0100 0000 0000
C 4 1 0100 0000 0000
C 4 1 0100 0000 0000
C 4 1 0100 0000 0000
C 4 1 0100 0000 0000
C 4 1 0100 0000 0000
C 4 1 0100 0000 0000
C 4 1 0100 0000 0000
E 0 04D0
C 1 1 0000 0000 0000
C 2 2 7FFF 7FFF 7FFF
C 2 2 7FFF 7FFF 7FFF
C 2 2 7FFF 7FFF 7FFF
C 4 1 0003 0000 0000
C 4 1 0001 0000 0000
C 4 1 0001 0000 0000
C 4 1 FFFB 0000 0000
C 4 1 7FFF 0000 0000
C 4 1 8000 0000 0000
C 4 1 0010 0000 0000
C 4 1 FFFF 0000 0000
E 1 8011
C 5 1 0000 0000 0000
R 0003 0001 0001
C 5 1 0003 0000 0000
R FFFB 7FFF 8000
C 5 1 0005 0000 0000
R 8000 0010 FFFF
C 5 2 0000 0000 0000
C 5 0 0020 0000 0000
G 3
